// ==== verilog/cache_geom_pkg.sv ====
package cache_geom_pkg;

    // cache shape, fixed for this design
    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int offset_bits = 5;
    localparam int index_bits  = 4;
    localparam int tag_bits    = 32 - index_bits - offset_bits;
    localparam int line_bits   = 256;

    // tree plru over four ways needs three bits
    localparam int plru_bits   = 3;

    // byte address as seen by the arbiter
    typedef logic [31:0]            addr_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;

    // one full cache line
    typedef logic [line_bits-1:0]   line_t;

    typedef logic [1:0]             way_t;

    // one bit per way, used for valid, dirty and hit
    typedef logic [num_ways-1:0]    way_mask_t;

    typedef logic [plru_bits-1:0]   plru_t;

endpackage : cache_geom_pkg

// ==== verilog/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // controller states
    //   idle      wait for a request from the arbiter
    //   compare   tag lookup, respond on a hit
    //   writeback push the dirty victim out to memory
    //   allocate  fetch the requested line from memory
    typedef enum logic [1:0] {
        idle      = 2'd0,
        compare   = 2'd1,
        writeback = 2'd2,
        allocate  = 2'd3
    } cache_state_t;

endpackage : cache_ctrl_pkg

// ==== verilog/cache_ctrl_if.sv ====
interface cache_ctrl_if;

    // array load strobes
    logic load_data;
    logic load_tag;
    logic load_dirty;
    logic load_plru;
    logic dirty_in;

    // steer datapath muxes toward the victim or the fill
    logic is_allocate;
    logic use_replace;

    // lookup status back to the FSM
    logic is_hit;
    logic is_dirty;

    modport control (
        output load_data, load_tag, load_dirty, load_plru, dirty_in,
        output is_allocate, use_replace,
        input  is_hit, is_dirty
    );

    modport datapath (
        input  load_data, load_tag, load_dirty, load_plru, dirty_in,
        input  is_allocate, use_replace,
        output is_hit, is_dirty
    );

endinterface : cache_ctrl_if

// ==== verilog/l2_tag_store.sv ====
module l2_tag_store (
    input  logic                       clk,
    input  logic                       rst_n,

    input  cache_geom_pkg::index_t     index,
    input  cache_geom_pkg::tag_t       tag,
    input  cache_geom_pkg::way_t       way,

    input  logic                       load_tag,
    input  logic                       load_dirty,
    input  logic                       dirty_in,

    output cache_geom_pkg::way_mask_t  hit_mask,
    output cache_geom_pkg::way_mask_t  valid_mask,
    output cache_geom_pkg::way_mask_t  dirty_mask,

    input  cache_geom_pkg::way_t       victim_tag_sel,
    output cache_geom_pkg::tag_t       victim_tag
);

    import cache_geom_pkg::*;

    tag_t      tags  [num_sets][num_ways];
    way_mask_t valid [num_sets];
    way_mask_t dirty [num_sets];

    always_ff @(posedge clk) begin
        if (load_tag) begin
            tags[index][way] <= tag;
        end
    end

    // every tag load makes the way valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (load_tag) begin
                valid[index][way] <= 1'b1;
            end
            if (load_dirty) begin
                dirty[index][way] <= dirty_in;
            end
        end
    end

    // all ways compared at once
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_mask[w] = valid[index][w] && (tags[index][w] == tag);
        end
    end

    assign valid_mask = valid[index];
    assign dirty_mask = dirty[index];
    assign victim_tag = tags[index][victim_tag_sel];

endmodule : l2_tag_store

// ==== verilog/l2_data_store.sv ====
module l2_data_store (
    input  logic                    clk,

    input  cache_geom_pkg::index_t  index,
    input  cache_geom_pkg::way_t    way,
    input  logic                    load,
    input  cache_geom_pkg::line_t   wdata,

    input  cache_geom_pkg::way_t    rd_way,
    output cache_geom_pkg::line_t   rdata
);

    import cache_geom_pkg::*;

    line_t lines [num_sets][num_ways];

    // one way written per edge
    always_ff @(posedge clk) begin
        if (load) begin
            lines[index][way] <= wdata;
        end
    end

    // async read of any way
    assign rdata = lines[index][rd_way];

endmodule : l2_data_store

// ==== verilog/l2_plru.sv ====
module l2_plru (
    input  logic                    clk,
    input  logic                    rst_n,

    input  cache_geom_pkg::index_t  index,
    input  cache_geom_pkg::way_t    touch_way,
    input  logic                    load,

    output cache_geom_pkg::way_t    victim
);

    import cache_geom_pkg::*;

    // bit 2 root    1 when ways 0-1 touched last
    // bit 1 left    1 when way 0 touched last in its pair
    // bit 0 right   1 when way 2 touched last in its pair
    plru_t tree [num_sets];
    plru_t cur;

    assign cur = tree[index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (load) begin
            if (!touch_way[1]) begin
                tree[index][2] <= 1'b1;
                tree[index][1] <= (touch_way == 2'd0);
            end else begin
                tree[index][2] <= 1'b0;
                tree[index][0] <= (touch_way == 2'd2);
            end
        end
    end

    // walk away from the most recent side
    always_comb begin
        if (cur[2]) begin
            victim = cur[0] ? 2'd3 : 2'd2;
        end else begin
            victim = cur[1] ? 2'd1 : 2'd0;
        end
    end

endmodule : l2_plru

// ==== verilog/l2_cache_datapath.sv ====
module l2_cache_datapath (
    input  logic                   clk,
    input  logic                   rst_n,

    input  cache_geom_pkg::addr_t  mem_address,
    input  cache_geom_pkg::line_t  mem_wdata,
    output cache_geom_pkg::line_t  mem_rdata,

    input  cache_geom_pkg::line_t  pmem_rdata,
    output cache_geom_pkg::line_t  pmem_wdata,
    output cache_geom_pkg::addr_t  pmem_address,

    cache_ctrl_if.datapath         ctrl
);

    import cache_geom_pkg::*;

    tag_t      tag;
    index_t    index;
    way_mask_t hit_mask;
    way_mask_t valid_mask;
    way_mask_t dirty_mask;
    way_t      hit_way;
    way_t      plru_victim;
    way_t      victim_way;
    way_t      target_way;
    tag_t      victim_tag;
    line_t     store_wdata;
    line_t     line_out;

    assign tag   = mem_address[offset_bits+index_bits +: tag_bits];
    assign index = mem_address[offset_bits +: index_bits];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_mask[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // an empty way always wins over the plru choice
    always_comb begin
        victim_way = plru_victim;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    assign target_way  = ctrl.use_replace ? victim_way : hit_way;
    assign store_wdata = ctrl.is_allocate ? pmem_rdata : mem_wdata;

    assign ctrl.is_hit   = |hit_mask;
    assign ctrl.is_dirty = valid_mask[victim_way] & dirty_mask[victim_way];

    // victim line address only while writing back
    assign pmem_address = (ctrl.use_replace && !ctrl.is_allocate)
                        ? {victim_tag, index, {offset_bits{1'b0}}}
                        : {tag, index, {offset_bits{1'b0}}};

    // single read port serves both sides
    assign mem_rdata  = line_out;
    assign pmem_wdata = line_out;

    l2_tag_store tag_store_i (
        .clk,
        .rst_n,
        .index,
        .tag,
        .way            (target_way),
        .load_tag       (ctrl.load_tag),
        .load_dirty     (ctrl.load_dirty),
        .dirty_in       (ctrl.dirty_in),
        .hit_mask,
        .valid_mask,
        .dirty_mask,
        .victim_tag_sel (victim_way),
        .victim_tag
    );

    l2_data_store data_store_i (
        .clk,
        .index,
        .way    (target_way),
        .load   (ctrl.load_data),
        .wdata  (store_wdata),
        .rd_way (target_way),
        .rdata  (line_out)
    );

    l2_plru plru_i (
        .clk,
        .rst_n,
        .index,
        .touch_way (hit_way),
        .load      (ctrl.load_plru),
        .victim    (plru_victim)
    );

endmodule : l2_cache_datapath

// ==== verilog/l2_cache_control.sv ====
module l2_cache_control (
    input  logic          clk,
    input  logic          rst_n,

    // arbiter side
    input  logic          mem_read,
    input  logic          mem_write,
    output logic          mem_resp,

    // adaptor side
    output logic          pmem_read,
    output logic          pmem_write,
    input  logic          pmem_resp,

    cache_ctrl_if.control ctrl
);

    import cache_ctrl_pkg::*;

    cache_state_t state;
    cache_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next       = state;
        mem_resp         = 1'b0;
        pmem_read        = 1'b0;
        pmem_write       = 1'b0;
        ctrl.load_data   = 1'b0;
        ctrl.load_tag    = 1'b0;
        ctrl.load_dirty  = 1'b0;
        ctrl.load_plru   = 1'b0;
        ctrl.dirty_in    = 1'b0;
        ctrl.is_allocate = 1'b0;
        ctrl.use_replace = 1'b0;

        case (state)
            idle: begin
                if (mem_read || mem_write) begin
                    state_next = compare;
                end
            end

            compare: begin
                if (ctrl.is_hit) begin
                    mem_resp       = 1'b1;
                    ctrl.load_plru = 1'b1;
                    // write hit replaces the whole line and marks it dirty
                    if (mem_write) begin
                        ctrl.load_data  = 1'b1;
                        ctrl.load_dirty = 1'b1;
                        ctrl.dirty_in   = 1'b1;
                    end
                    state_next = idle;
                end else if (ctrl.is_dirty) begin
                    state_next = writeback;
                end else begin
                    state_next = allocate;
                end
            end

            writeback: begin
                ctrl.use_replace = 1'b1;
                pmem_write       = 1'b1;
                if (pmem_resp) begin
                    state_next = allocate;
                end
            end

            allocate: begin
                ctrl.use_replace = 1'b1;
                ctrl.is_allocate = 1'b1;
                pmem_read        = 1'b1;
                // fill lands clean, then compare again to serve the request
                if (pmem_resp) begin
                    ctrl.load_data  = 1'b1;
                    ctrl.load_tag   = 1'b1;
                    ctrl.load_dirty = 1'b1;
                    ctrl.dirty_in   = 1'b0;
                    state_next      = compare;
                end
            end

            default: begin
                state_next = idle;
            end
        endcase
    end

endmodule : l2_cache_control

// ==== verilog/l2_cache.sv ====
module l2_cache (
    input  logic                   clk,
    input  logic                   rst_n,

    // arbiter side
    input  cache_geom_pkg::addr_t  mem_address,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  cache_geom_pkg::line_t  mem_wdata,
    output cache_geom_pkg::line_t  mem_rdata,
    output logic                   mem_resp,

    // cacheline adaptor side
    output cache_geom_pkg::addr_t  pmem_address,
    output logic                   pmem_read,
    output logic                   pmem_write,
    output cache_geom_pkg::line_t  pmem_wdata,
    input  cache_geom_pkg::line_t  pmem_rdata,
    input  logic                   pmem_resp
);

    cache_ctrl_if ctrl_if ();

    l2_cache_control control_i (
        .clk,
        .rst_n,
        .mem_read,
        .mem_write,
        .mem_resp,
        .pmem_read,
        .pmem_write,
        .pmem_resp,
        .ctrl       (ctrl_if.control)
    );

    l2_cache_datapath datapath_i (
        .clk,
        .rst_n,
        .mem_address,
        .mem_wdata,
        .mem_rdata,
        .pmem_rdata,
        .pmem_wdata,
        .pmem_address,
        .ctrl         (ctrl_if.datapath)
    );

endmodule : l2_cache

// ==== dv/l2_mem_model.sv ====
module l2_mem_model #(
    parameter int mem_lines = 128
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_geom_pkg::addr_t  pmem_address,
    input  logic                   pmem_read,
    input  logic                   pmem_write,
    input  cache_geom_pkg::line_t  pmem_wdata,
    output cache_geom_pkg::line_t  pmem_rdata,
    output logic                   pmem_resp
);

    import cache_geom_pkg::*;

    line_t lines [mem_lines];
    int    wait_cnt;

    // every word mixes its line number with its slot in the line
    initial begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        for (int i = 0; i < mem_lines; i++) begin
            for (int k = 0; k < line_bits / 32; k++) begin
                lines[i][k*32 +: 32] = (i * 32'h9e37_79b9) ^ (k << 28) ^ i;
            end
        end
    end

    // serves one request at a time after 1 to 5 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt  <= 0;
            pmem_resp <= 1'b0;
        end else begin
            pmem_resp <= 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt <= wait_cnt - 1;
                if (wait_cnt == 1) begin
                    pmem_resp <= 1'b1;
                    if (pmem_write)
                        lines[(pmem_address >> offset_bits) % mem_lines] <= pmem_wdata;
                    else
                        pmem_rdata <= lines[(pmem_address >> offset_bits) % mem_lines];
                end
            end else if (!pmem_resp && (pmem_read || pmem_write)) begin
                wait_cnt <= $urandom_range(5, 1);
            end
        end
    end

endmodule : l2_mem_model

// ==== dv/l2_cache_tb.sv ====
module l2_cache_tb;

    import cache_geom_pkg::*;

    localparam int resp_timeout = 100;
    localparam int num_random   = 300;
    localparam int mem_lines    = 128;

    logic  clk;
    logic  rst_n;
    logic  mem_read;
    logic  mem_write;
    logic  mem_resp;
    logic  pmem_read;
    logic  pmem_write;
    logic  pmem_resp;
    addr_t mem_address;
    addr_t pmem_address;
    line_t mem_wdata;
    line_t mem_rdata;
    line_t pmem_wdata;
    line_t pmem_rdata;

    // reference copy of the cache arrays and of memory
    tag_t  ref_tag   [num_sets][num_ways];
    logic  ref_valid [num_sets][num_ways];
    logic  ref_dirty [num_sets][num_ways];
    line_t ref_data  [num_sets][num_ways];
    plru_t ref_plru  [num_sets];
    line_t shadow    [mem_lines];

    // memory side traffic seen during one access
    addr_t rd_seen [$];
    addr_t wr_seen [$];
    line_t wr_data_seen [$];
    int    errors;

    l2_cache l2_cache_i (.*);

    l2_mem_model #(.mem_lines(mem_lines)) mem_model_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (pmem_resp && pmem_read)
            rd_seen.push_back(pmem_address);
        if (pmem_resp && pmem_write) begin
            wr_seen.push_back(pmem_address);
            wr_data_seen.push_back(pmem_wdata);
        end
    end

    task automatic check_equal(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("Mismatch %s: expected %0h actual %0h", name, expected, actual);
        end
    endtask

    function automatic addr_t line_addr(input int tg, input int idx);
        return {tag_t'(tg), index_t'(idx), {offset_bits{1'b0}}};
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < line_bits / 32; k++)
            l[k*32 +: 32] = $urandom;
        return l;
    endfunction

    // one arbiter request, predicted by the model and then checked
    task automatic run_access(input string name, input addr_t addr, input logic wr,
                              input line_t wdata);
        index_t idx;
        int     way;
        int     cycles;
        logic   hit;
        logic   wb;
        line_t  exp_rdata;
        addr_t  wb_addr;
        line_t  wb_data;
        idx = addr[offset_bits +: index_bits];
        way = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == addr[31 -: tag_bits])
                way = w;
        end
        hit = (way >= 0);
        wb  = 1'b0;
        // lowest empty way first, else follow the tree away from recent use
        if (!hit) begin
            way = ref_plru[idx][2] ? (ref_plru[idx][0] ? 3 : 2) : (ref_plru[idx][1] ? 1 : 0);
            for (int w = num_ways - 1; w >= 0; w--) begin
                if (!ref_valid[idx][w])
                    way = w;
            end
            wb      = ref_valid[idx][way] && ref_dirty[idx][way];
            wb_addr = {ref_tag[idx][way], idx, {offset_bits{1'b0}}};
            wb_data = ref_data[idx][way];
            if (wb)
                shadow[wb_addr >> offset_bits] = wb_data;
            ref_tag[idx][way]   = addr[31 -: tag_bits];
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
            ref_data[idx][way]  = shadow[addr >> offset_bits];
        end
        exp_rdata = ref_data[idx][way];
        if (wr) begin
            ref_data[idx][way]  = wdata;
            ref_dirty[idx][way] = 1'b1;
        end
        ref_plru[idx][2] = (way < 2);
        if (way < 2)
            ref_plru[idx][1] = (way == 0);
        else
            ref_plru[idx][0] = (way == 2);

        rd_seen.delete();
        wr_seen.delete();
        wr_data_seen.delete();
        mem_address <= addr;
        mem_read    <= !wr;
        mem_write   <= wr;
        mem_wdata   <= wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!mem_resp && cycles < resp_timeout);
        if (!mem_resp) begin
            errors++;
            $display("%s: no mem_resp within %0d cycles, cache state %s", name, cycles,
                     l2_cache_i.control_i.state.name());
        end else begin
            if (!wr)
                check_equal({name, " read data"}, exp_rdata, mem_rdata);
            if (hit)
                check_equal({name, " hit latency"}, 2, cycles);
            check_equal({name, " fill count"}, !hit, rd_seen.size());
            check_equal({name, " writeback count"}, wb, wr_seen.size());
            if (!hit && rd_seen.size() == 1)
                check_equal({name, " fill address"},
                            {addr[31:offset_bits], {offset_bits{1'b0}}}, rd_seen[0]);
            if (wb && wr_seen.size() == 1) begin
                check_equal({name, " writeback address"}, wb_addr, wr_seen[0]);
                check_equal({name, " writeback data"}, wb_data, wr_data_seen[0]);
            end
        end
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        int   tg;
        int   idx;
        logic wr;
        void'($urandom(32'h153c));
        errors      = 0;
        rst_n       = 1'b0;
        mem_address = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_wdata   = '0;
        for (int s = 0; s < num_sets; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end

        // quiet through 10 reset cycles and the cycle after release
        for (int c = 0; c <= 10; c++) begin
            @(posedge clk);
            check_equal("reset mem_resp", 0, mem_resp);
            check_equal("reset pmem_read", 0, pmem_read);
            check_equal("reset pmem_write", 0, pmem_write);
            if (c == 9)
                rst_n <= 1'b1;
        end
        for (int i = 0; i < mem_lines; i++)
            shadow[i] = mem_model_i.lines[i];

        run_access("read_miss", line_addr(1, 3), 1'b0, '0);
        run_access("read_hit", line_addr(1, 3), 1'b0, '0);
        run_access("write_hit", line_addr(1, 3), 1'b1, random_line());
        run_access("read_after_write", line_addr(1, 3), 1'b0, '0);

        // eight tags through set 7, even tags written, so victims are mixed
        for (int i = 0; i < 8; i++)
            run_access($sformatf("plru_tag%0d", i), line_addr(i, 7), i % 2 == 0, random_line());

        for (int i = 0; i < num_random; i++) begin
            tg  = $urandom_range(7, 0);
            idx = $urandom_range(3, 0);
            wr  = $urandom_range(1, 0);
            run_access("random", line_addr(tg, idx), wr, random_line());
        end

        $display("accesses %0d, errors %0d", num_random + 12, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : l2_cache_tb

// ==== verilog.f ====
verilog/cache_geom_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/cache_ctrl_if.sv
verilog/l2_tag_store.sv
verilog/l2_data_store.sv
verilog/l2_plru.sv
verilog/l2_cache_datapath.sv
verilog/l2_cache_control.sv
verilog/l2_cache.sv
dv/l2_mem_model.sv
dv/l2_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2_cache

sources:
  - verilog/cache_geom_pkg.sv
  - verilog/cache_ctrl_pkg.sv
  - verilog/cache_ctrl_if.sv
  - verilog/l2_tag_store.sv
  - verilog/l2_data_store.sv
  - verilog/l2_plru.sv
  - verilog/l2_cache_datapath.sv
  - verilog/l2_cache_control.sv
  - verilog/l2_cache.sv
  - target: test
    files:
      - dv/l2_mem_model.sv
      - dv/l2_cache_tb.sv
